//--- Bender.yml
package:
  name: core_slice

sources:
  - rv_core_pkg.sv
  - reg_file.sv
  - decode_stage.sv
  - execute_stage.sv
  - memory_stage.sv
  - core_slice.sv
  - target: simulation
    files:
      - tb_core_slice.sv

//--- core_slice.sv
`timescale 1ns/1ps

module core_slice import rv_core_pkg::*; #(
	parameter int dmem_words = 64
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  in_valid,
	output logic                  in_ready,
	input  logic [xlen-1:0]       in_inst,
	input  logic [xlen-1:0]       in_pc,
	output logic                  redirect,
	output logic [xlen-1:0]       redirect_target,
	output logic                  wb_valid,
	output logic [reg_addr_w-1:0] wb_rd,
	output logic [xlen-1:0]       wb_data,
	output logic                  store_valid,
	output logic [xlen-1:0]       store_addr,
	output logic [xlen-1:0]       store_data
);

	logic [reg_addr_w-1:0] rs1, rs2;
	logic [xlen-1:0]       rdata1, rdata2;
	logic                  fwd_ex_valid, fwd_mem_valid;
	logic [reg_addr_w-1:0] fwd_ex_rd, fwd_mem_rd;
	logic [xlen-1:0]       fwd_ex_value, fwd_mem_value;
	logic                  ex_is_load, mem_load_pending;
	logic                  ex_valid, ex_ready, ex_wen;
	inst_class_e           ex_class;
	logic [reg_addr_w-1:0] ex_rd;
	logic [xlen-1:0]       ex_pc, ex_src1, ex_src2, ex_imm;
	logic                  mem_valid, mem_ready, mem_wen;
	inst_class_e           mem_class;
	logic [reg_addr_w-1:0] mem_rd;
	logic [xlen-1:0]       mem_value, mem_store_data;

	reg_file u_reg_file (.clock, .reset, .rs1, .rs2, .rdata1, .rdata2,
		.wen(wb_valid), .waddr(wb_rd), .wdata(wb_data));

	decode_stage u_decode_stage (.clock, .reset, .in_valid, .in_ready, .in_inst, .in_pc,
		.rs1, .rs2, .rdata1, .rdata2, .fwd_ex_valid, .fwd_ex_rd, .fwd_ex_value,
		.fwd_mem_valid, .fwd_mem_rd, .fwd_mem_value, .ex_is_load, .mem_load_pending,
		.redirect, .ex_valid, .ex_ready, .ex_class, .ex_rd, .ex_wen, .ex_pc,
		.ex_src1, .ex_src2, .ex_imm);

	execute_stage u_execute_stage (.clock, .reset, .ex_valid, .ex_ready, .ex_class,
		.ex_rd, .ex_wen, .ex_pc, .ex_src1, .ex_src2, .ex_imm, .fwd_ex_valid, .fwd_ex_rd,
		.fwd_ex_value, .ex_is_load, .redirect, .redirect_target, .mem_valid, .mem_ready,
		.mem_class, .mem_rd, .mem_wen, .mem_value, .mem_store_data);

	memory_stage #(.dmem_words(dmem_words)) u_memory_stage (.clock, .reset, .mem_valid,
		.mem_ready, .mem_class, .mem_rd, .mem_wen, .mem_value, .mem_store_data,
		.fwd_mem_valid, .fwd_mem_rd, .fwd_mem_value, .mem_load_pending, .wb_valid,
		.wb_rd, .wb_data, .store_valid, .store_addr, .store_data);

endmodule

//--- decode_stage.sv
`timescale 1ns/1ps

module decode_stage import rv_core_pkg::*; (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  in_valid,
	output logic                  in_ready,
	input  logic [xlen-1:0]       in_inst,
	input  logic [xlen-1:0]       in_pc,
	output logic [reg_addr_w-1:0] rs1,
	output logic [reg_addr_w-1:0] rs2,
	input  logic [xlen-1:0]       rdata1,
	input  logic [xlen-1:0]       rdata2,
	input  logic                  fwd_ex_valid,
	input  logic [reg_addr_w-1:0] fwd_ex_rd,
	input  logic [xlen-1:0]       fwd_ex_value,
	input  logic                  fwd_mem_valid,
	input  logic [reg_addr_w-1:0] fwd_mem_rd,
	input  logic [xlen-1:0]       fwd_mem_value,
	input  logic                  ex_is_load,
	input  logic                  mem_load_pending,
	input  logic                  redirect,
	output logic                  ex_valid,
	input  logic                  ex_ready,
	output inst_class_e           ex_class,
	output logic [reg_addr_w-1:0] ex_rd,
	output logic                  ex_wen,
	output logic [xlen-1:0]       ex_pc,
	output logic [xlen-1:0]       ex_src1,
	output logic [xlen-1:0]       ex_src2,
	output logic [xlen-1:0]       ex_imm
);

	opcode_e               opcode;
	inst_class_e           dec_class;
	logic [reg_addr_w-1:0] dec_rd;
	logic [xlen-1:0]       dec_imm;
	logic [xlen-1:0]       src1;
	logic [xlen-1:0]       src2;
	logic                  need_rs1;
	logic                  need_rs2;
	logic                  dec_wen;
	logic                  rs1_hazard;
	logic                  rs2_hazard;
	logic                  accept;

	assign opcode = opcode_e'(in_inst[6:0]);
	assign dec_rd = in_inst[10:7];
	assign rs1    = in_inst[18:15];
	assign rs2    = in_inst[23:20];

	always_comb begin
		case (opcode)
			opc_lui:    dec_class = cls_lui;
			opc_auipc:  dec_class = cls_auipc;
			opc_jal:    dec_class = cls_jal;
			opc_jalr:   dec_class = cls_jalr;
			opc_branch: dec_class = cls_beq; // every funct3 taken as beq.
			opc_load:   dec_class = cls_lw;
			opc_store:  dec_class = cls_sw;
			opc_op_imm: dec_class = cls_addi;
			opc_op:     dec_class = cls_add;
			default:    dec_class = cls_none;
		endcase
	end

	always_comb begin
		case (dec_class)
			cls_jalr, cls_lw, cls_addi: dec_imm = {{20{in_inst[31]}}, in_inst[31:20]};
			cls_sw:  dec_imm = {{20{in_inst[31]}}, in_inst[31:25], in_inst[11:7]};
			cls_beq: dec_imm = {{20{in_inst[31]}}, in_inst[7], in_inst[30:25],
				in_inst[11:8], 1'b0};
			cls_lui, cls_auipc: dec_imm = {in_inst[31:12], 12'b0};
			cls_jal: dec_imm = {{12{in_inst[31]}}, in_inst[19:12], in_inst[20],
				in_inst[30:21], 1'b0};
			default: dec_imm = '0;
		endcase
	end

	assign need_rs2 = dec_class inside {cls_beq, cls_sw, cls_add};
	assign need_rs1 = need_rs2 || (dec_class inside {cls_jalr, cls_lw, cls_addi});
	assign dec_wen  = (dec_class inside {cls_lui, cls_auipc, cls_jal, cls_jalr, cls_lw,
		cls_addi, cls_add}) && dec_rd != '0; // no write-back for x0.

	// load data not yet available for this source.
	assign rs1_hazard = need_rs1 && rs1 != '0 && ((ex_is_load && fwd_ex_rd == rs1) ||
		(mem_load_pending && fwd_mem_rd == rs1));
	assign rs2_hazard = need_rs2 && rs2 != '0 && ((ex_is_load && fwd_ex_rd == rs2) ||
		(mem_load_pending && fwd_mem_rd == rs2));

	function automatic logic [xlen-1:0] pick_operand(input logic [reg_addr_w-1:0] rs,
		input logic [xlen-1:0] rdata);
		if (fwd_ex_valid && fwd_ex_rd == rs)
			return fwd_ex_value; // youngest result wins.
		if (fwd_mem_valid && fwd_mem_rd == rs)
			return fwd_mem_value;
		return rdata;
	endfunction

	always_comb begin
		src1 = pick_operand(rs1, rdata1);
		src2 = pick_operand(rs2, rdata2);
	end

	assign in_ready = !ex_valid && !rs1_hazard && !rs2_hazard && !redirect;
	assign accept   = in_valid && in_ready;

	always_ff @(posedge clock) begin
		if (reset || redirect)
			ex_valid <= 1'b0; // wrong-path item is dropped.
		else if (ex_valid && ex_ready)
			ex_valid <= 1'b0;
		else if (accept)
			ex_valid <= 1'b1;
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			ex_class <= dec_class;
			ex_rd    <= dec_rd;
			ex_wen   <= dec_wen;
			ex_pc    <= in_pc;
			ex_src1  <= src1;
			ex_src2  <= src2;
			ex_imm   <= dec_imm;
		end
	end

	a_flush: assert property (@(posedge clock) disable iff (reset)
		redirect |-> !(ex_valid && ex_ready))
		else $error("decode item handed to execute on a redirect");

endmodule

//--- execute_stage.sv
`timescale 1ns/1ps

module execute_stage import rv_core_pkg::*; (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  ex_valid,
	output logic                  ex_ready,
	input  inst_class_e           ex_class,
	input  logic [reg_addr_w-1:0] ex_rd,
	input  logic                  ex_wen,
	input  logic [xlen-1:0]       ex_pc,
	input  logic [xlen-1:0]       ex_src1,
	input  logic [xlen-1:0]       ex_src2,
	input  logic [xlen-1:0]       ex_imm,
	output logic                  fwd_ex_valid,
	output logic [reg_addr_w-1:0] fwd_ex_rd,
	output logic [xlen-1:0]       fwd_ex_value,
	output logic                  ex_is_load,
	output logic                  redirect,
	output logic [xlen-1:0]       redirect_target,
	output logic                  mem_valid,
	input  logic                  mem_ready,
	output inst_class_e           mem_class,
	output logic [reg_addr_w-1:0] mem_rd,
	output logic                  mem_wen,
	output logic [xlen-1:0]       mem_value,
	output logic [xlen-1:0]       mem_store_data
);

	logic [xlen-1:0] base_sum;
	logic [xlen-1:0] pc_target;
	logic [xlen-1:0] result;
	logic [xlen-1:0] target;
	logic            taken;
	logic            taken_q;
	logic [xlen-1:0] target_q;
	logic            accept;

	assign base_sum  = ex_src1 + ex_imm;
	assign pc_target = ex_pc + ex_imm;

	always_comb begin
		case (ex_class)
			cls_add:                   result = ex_src1 + ex_src2;
			cls_addi, cls_lw, cls_sw:  result = base_sum;
			cls_lui:                   result = ex_imm;
			cls_auipc, cls_beq:        result = pc_target;
			cls_jal, cls_jalr:         result = ex_pc + 32'd4; // link value.
			default:                   result = '0;
		endcase
	end

	assign taken  = (ex_class inside {cls_jal, cls_jalr}) ||
		(ex_class == cls_beq && ex_src1 == ex_src2);
	assign target = (ex_class == cls_jalr) ? {base_sum[xlen-1:1], 1'b0} : pc_target;

	assign redirect        = mem_valid && mem_ready && taken_q;
	assign redirect_target = target_q;
	assign ex_ready        = (!mem_valid || mem_ready) && !redirect;
	assign accept          = ex_valid && ex_ready;

	always_ff @(posedge clock) begin
		if (reset)
			mem_valid <= 1'b0;
		else if (accept)
			mem_valid <= 1'b1;
		else if (mem_ready)
			mem_valid <= 1'b0;
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			mem_class      <= ex_class;
			mem_rd         <= ex_rd;
			mem_wen        <= ex_wen;
			mem_value      <= result;
			mem_store_data <= ex_src2;
			taken_q        <= taken;
			target_q       <= target;
		end
	end

	assign ex_is_load   = mem_valid && mem_class == cls_lw;
	assign fwd_ex_valid = mem_valid && mem_wen && mem_class != cls_lw;
	assign fwd_ex_rd    = mem_rd;
	assign fwd_ex_value = mem_value;

endmodule

//--- filelist.f
rv_core_pkg.sv
reg_file.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
core_slice.sv
tb_core_slice.sv

//--- memory_stage.sv
`timescale 1ns/1ps

module memory_stage import rv_core_pkg::*; #(
	parameter int dmem_words = 64
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  mem_valid,
	output logic                  mem_ready,
	input  inst_class_e           mem_class,
	input  logic [reg_addr_w-1:0] mem_rd,
	input  logic                  mem_wen,
	input  logic [xlen-1:0]       mem_value,
	input  logic [xlen-1:0]       mem_store_data,
	output logic                  fwd_mem_valid,
	output logic [reg_addr_w-1:0] fwd_mem_rd,
	output logic [xlen-1:0]       fwd_mem_value,
	output logic                  mem_load_pending,
	output logic                  wb_valid,
	output logic [reg_addr_w-1:0] wb_rd,
	output logic [xlen-1:0]       wb_data,
	output logic                  store_valid,
	output logic [xlen-1:0]       store_addr,
	output logic [xlen-1:0]       store_data
);

	localparam int idx_w = $clog2(dmem_words);

	mem_state_e            state;
	inst_class_e           class_q;
	logic [reg_addr_w-1:0] rd_q;
	logic                  wen_q;
	logic [xlen-1:0]       value_q; // result, address, then load data.
	logic [xlen-1:0]       data_q;
	logic [idx_w-1:0]      word_index;
	logic [xlen-1:0]       dmem [dmem_words];

	assign word_index = value_q[idx_w+1:2];
	assign mem_ready  = state == mem_idle;

	always_ff @(posedge clock) begin
		if (reset)
			state <= mem_idle;
		else case (state)
			mem_idle: begin
				if (mem_valid)
					state <= (mem_class == cls_lw) ? mem_load_read : rv_core_pkg::mem_ready;
			end
			mem_load_read: state <= rv_core_pkg::mem_ready;
			default:       state <= mem_idle;
		endcase
	end

	always_ff @(posedge clock) begin
		if (mem_valid && mem_ready) begin
			class_q <= mem_class;
			rd_q    <= mem_rd;
			wen_q   <= mem_wen;
			value_q <= mem_value;
			data_q  <= mem_store_data;
		end else if (state == mem_load_read) begin
			value_q <= dmem[word_index];
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < dmem_words; i++)
				dmem[i] <= '0;
		end else if (store_valid) begin
			dmem[word_index] <= data_q;
		end
	end

	assign wb_valid    = state == rv_core_pkg::mem_ready && wen_q;
	assign wb_rd       = rd_q;
	assign wb_data     = value_q;
	assign store_valid = state == rv_core_pkg::mem_ready && class_q == cls_sw;
	assign store_addr  = value_q;
	assign store_data  = data_q;

	assign fwd_mem_valid    = wb_valid;
	assign fwd_mem_rd       = rd_q;
	assign fwd_mem_value    = value_q;
	assign mem_load_pending = state == mem_load_read;

	a_one_report: assert property (@(posedge clock) disable iff (reset)
		!(wb_valid && store_valid))
		else $error("write-back and store reported together");

endmodule

//--- reg_file.sv
`timescale 1ns/1ps

module reg_file import rv_core_pkg::*; (
	input  logic                  clock,
	input  logic                  reset,
	input  logic [reg_addr_w-1:0] rs1,
	input  logic [reg_addr_w-1:0] rs2,
	output logic [xlen-1:0]       rdata1,
	output logic [xlen-1:0]       rdata2,
	input  logic                  wen,
	input  logic [reg_addr_w-1:0] waddr,
	input  logic [xlen-1:0]       wdata
);

	logic [xlen-1:0] regs [1 << reg_addr_w];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < (1 << reg_addr_w); i++)
				regs[i] <= '0;
		end else if (wen && waddr != '0) begin // x0 writes are dropped.
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
	assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

	a_x0_zero: assert property (@(posedge clock) disable iff (reset) regs[0] == '0)
		else $error("x0 holds a nonzero value");

endmodule

//--- rv_core_pkg.sv
package rv_core_pkg;

	localparam int xlen = 32;
	localparam int reg_addr_w = 4; // rv32e has sixteen registers.

	// decoded operation, one value per supported instruction.
	typedef enum logic [3:0] {
		cls_lui,
		cls_auipc,
		cls_jal,
		cls_jalr,
		cls_beq,
		cls_lw,
		cls_sw,
		cls_addi,
		cls_add,
		cls_none
	} inst_class_e;

	// major opcodes in bits 6:0 of the instruction word.
	typedef enum logic [6:0] {
		opc_lui    = 7'b0110111,
		opc_auipc  = 7'b0010111,
		opc_jal    = 7'b1101111,
		opc_jalr   = 7'b1100111,
		opc_branch = 7'b1100011,
		opc_load   = 7'b0000011,
		opc_store  = 7'b0100011,
		opc_op_imm = 7'b0010011,
		opc_op     = 7'b0110011
	} opcode_e;

	typedef enum logic [1:0] {
		mem_idle,
		mem_load_read,
		mem_ready
	} mem_state_e;

endpackage

//--- tb_core_slice.sv
`timescale 1ns/1ps

module tb_core_slice import rv_core_pkg::*; ();

	localparam int n_tests = 5;
	localparam int n_ret = 48; // write-backs and stores per test.
	localparam int timeout_cycles = 40 * n_ret * n_tests;
	// allowed classes per test, bit index is the inst_class_e value.
	localparam logic [8:0] class_mix [5] = '{9'h183, 9'h1e0, 9'h19e, 9'h0e1, 9'h1ff};

	logic                  clock = 1'b0;
	logic                  reset, in_valid, in_ready, redirect, wb_valid, store_valid;
	logic [xlen-1:0]       in_inst, in_pc, redirect_target, wb_data, store_addr, store_data;
	logic [reg_addr_w-1:0] wb_rd;

	int    seed = 32'ha4e6_8cb1;
	int    errors = 0;
	int    checks = 0;
	int    nrep = 0;
	int    cycles = 0;
	int    gap_pct = 0;
	logic  run = 1'b0;
	string test_name [5] = '{"alu", "hazards", "control", "memory", "mixed"};

	logic [xlen-1:0]       prog [64];
	inst_class_e           f_class [64];
	logic [reg_addr_w-1:0] f_rd [64], f_rs1 [64], f_rs2 [64];
	logic [xlen-1:0]       f_imm [64];
	bit                    exp_store [$];
	logic [xlen-1:0]       exp_addr [$], exp_data [$]; // rd or store address, then data.

	core_slice #(.dmem_words(64)) u_core_slice (.clock, .reset, .in_valid, .in_ready,
		.in_inst, .in_pc, .redirect, .redirect_target, .wb_valid, .wb_rd, .wb_data,
		.store_valid, .store_addr, .store_data);

	initial forever #5 clock = ~clock;

	task automatic compare_value(input string name, input logic [xlen-1:0] got,
		input logic [xlen-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	function automatic logic [31:0] encode(inst_class_e c, logic [3:0] rd, logic [3:0] rs1,
		logic [3:0] rs2, logic [31:0] imm);
		logic [4:0] d, a, b;
		d = {1'b0, rd};
		a = {1'b0, rs1};
		b = {1'b0, rs2};
		case (c)
			cls_lui:   return {imm[31:12], d, opc_lui};
			cls_auipc: return {imm[31:12], d, opc_auipc};
			cls_jal:   return {imm[20], imm[10:1], imm[11], imm[19:12], d, opc_jal};
			cls_jalr:  return {imm[11:0], a, 3'b000, d, opc_jalr};
			cls_beq:   return {imm[12], imm[10:5], b, a, 3'b000, imm[4:1], imm[11], opc_branch};
			cls_lw:    return {imm[11:0], a, 3'b010, d, opc_load};
			cls_sw:    return {imm[11:5], b, a, 3'b010, imm[4:0], opc_store};
			cls_addi:  return {imm[11:0], a, 3'b000, d, opc_op_imm};
			default:   return {7'b0, b, a, 3'b000, d, opc_op};
		endcase
	endfunction

	task automatic build_program(input int kind);
		int r, k, amask;
		logic [3:0] rmask;
		logic [31:0] rnd;
		rmask = (kind == 1) ? 4'd3 : 4'd7; // fewer registers, denser hazards.
		amask = (kind == 3) ? 3 : 15;
		gap_pct = (kind == 0) ? 0 : (kind == 4) ? 50 : 20;
		for (int i = 0; i < 64; i++) begin
			do
				r = {$random(seed)} % 9;
			while (!class_mix[kind][r]);
			f_class[i] = (i == 0) ? cls_addi : inst_class_e'(r); // every pass writes at word 0.
			f_rd[i] = (i == 0) ? 4'd1 + 4'({$random(seed)} % 7) : 4'($random(seed)) & rmask;
			f_rs1[i] = 4'($random(seed)) & rmask;
			f_rs2[i] = ($random(seed) & 1) ? f_rs1[i] : 4'($random(seed)) & rmask;
			if (f_class[i] inside {cls_jalr, cls_lw, cls_sw})
				f_rs1[i] = '0; // absolute targets and addresses.
			k = 1 + {$random(seed)} % 4;
			if (i + k > 64)
				k = 64 - i; // forward only, at most to the wrap.
			rnd = $random(seed);
			case (f_class[i])
				cls_lui, cls_auipc: f_imm[i] = rnd & 32'hffff_f000;
				cls_jal, cls_beq:   f_imm[i] = k * 4;
				cls_jalr:           f_imm[i] = ((i + k) % 64) * 4;
				cls_lw, cls_sw:     f_imm[i] = (rnd & amask) * 4;
				default:            f_imm[i] = {{20{rnd[11]}}, rnd[11:0]};
			endcase
			prog[i] = encode(f_class[i], f_rd[i], f_rs1[i], f_rs2[i], f_imm[i]);
		end
	endtask

	task automatic run_model();
		logic [xlen-1:0] regs [16];
		logic [xlen-1:0] dmem [64];
		logic [xlen-1:0] pc, s1, s2, next, addr, val;
		logic wen;
		int i;
		regs = '{default: '0};
		dmem = '{default: '0};
		pc = '0;
		exp_store.delete();
		exp_addr.delete();
		exp_data.delete();
		while (exp_store.size() < n_ret) begin
			i = pc[7:2];
			s1 = regs[f_rs1[i]];
			s2 = regs[f_rs2[i]];
			next = pc + 4;
			addr = s1 + f_imm[i];
			wen = 1'b1;
			val = '0;
			case (f_class[i])
				cls_lui:   val = f_imm[i];
				cls_auipc: val = pc + f_imm[i];
				cls_jal, cls_jalr: begin
					val = next;
					next = (f_class[i] == cls_jal) ? pc + f_imm[i] : {addr[31:1], 1'b0};
				end
				cls_beq: begin
					wen = 1'b0;
					if (s1 == s2)
						next = pc + f_imm[i];
				end
				cls_lw:    val = dmem[addr[7:2]];
				cls_sw: begin
					wen = 1'b0;
					dmem[addr[7:2]] = s2;
					exp_store.push_back(1'b1);
					exp_addr.push_back(addr);
					exp_data.push_back(s2);
				end
				cls_addi:  val = addr;
				default:   val = s1 + s2;
			endcase
			if (wen && f_rd[i] != '0) begin
				regs[f_rd[i]] = val;
				exp_store.push_back(1'b0);
				exp_addr.push_back(f_rd[i]);
				exp_data.push_back(val);
			end
			pc = next;
		end
	endtask

	task automatic apply_reset();
		@(posedge clock);
		#1 reset = 1'b1;
		repeat (5) @(posedge clock);
		#1 reset = 1'b0;
	endtask

	// fetch source, holds its word while in_ready is low.
	initial begin
		logic xfer, redir;
		logic [xlen-1:0] pc, tgt;
		pc = '0;
		forever begin
			@(negedge clock);
			xfer = in_valid && in_ready;
			redir = redirect;
			tgt = redirect_target;
			@(posedge clock);
			#1;
			if (!run) begin
				in_valid = 1'b0;
				pc = '0;
			end else begin
				if (redir)
					pc = tgt;
				else if (xfer)
					pc = pc + 4;
				if (redir || xfer || !in_valid)
					in_valid = ({$random(seed)} % 100) >= gap_pct;
				in_inst = prog[pc[7:2]];
				in_pc = pc;
			end
		end
	end

	initial forever begin
		@(negedge clock);
		if (run && nrep < n_ret && (wb_valid || store_valid)) begin
			compare_value("store_valid", store_valid, exp_store[nrep]);
			if (store_valid) begin
				compare_value("store_addr", store_addr, exp_addr[nrep]);
				compare_value("store_data", store_data, exp_data[nrep]);
			end else begin
				compare_value("wb_rd", wb_rd, exp_addr[nrep]);
				compare_value("wb_data", wb_data, exp_data[nrep]);
			end
			nrep++;
		end
	end

	initial begin
		while (cycles < timeout_cycles)
			@(posedge clock) cycles++;
		$display("the core hung, no completion within %0d cycles", timeout_cycles);
		$display("Verification failed");
		$finish;
	end

	initial begin
		int errors_before;
		reset = 1'b1;
		in_valid = 1'b0;
		in_inst = '0;
		in_pc = '0;
		for (int t = 0; t < n_tests; t++) begin
			errors_before = errors;
			build_program(t);
			run_model();
			apply_reset();
			repeat (2) begin
				@(negedge clock);
				compare_value("in_ready", in_ready, 1'b1);
				compare_value("wb_valid", wb_valid, 1'b0);
				compare_value("store_valid", store_valid, 1'b0);
				compare_value("redirect", redirect, 1'b0);
			end
			@(posedge clock);
			nrep = 0;
			run = 1'b1;
			while (nrep < n_ret)
				@(posedge clock);
			run = 1'b0;
			$display("test %0d %s: %0d reports checked, %0d errors", t, test_name[t], nrep,
				errors - errors_before);
		end
		$display("tests %0d, checks %0d, errors %0d", n_tests, checks, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule
